// File: src.f
+incdir+.
ppu_pkg.sv
ppu_regs.sv
ppu_timing.sv
bg_fetcher.sv
pixel_fifo.sv
ppu.sv
tb_ppu.sv

// File: Bender.yml
package:
  name: ppu_bg

sources:
  - ppu_pkg.sv
  - ppu_regs.sv
  - ppu_timing.sv
  - bg_fetcher.sv
  - pixel_fifo.sv
  - ppu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ppu.sv

// File: tb_ppu_tasks.svh
`ifndef TB_PPU_TASKS_SVH
`define TB_PPU_TASKS_SVH

task automatic check_byte(input string name, input ppu_pkg::byte_t expected,
                          input ppu_pkg::byte_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED %s: expected %02h, actual %02h at %0t",
                 name, expected, actual, $time);
    end
endtask

task automatic check_color(input string name, input ppu_pkg::color_t expected,
                           input ppu_pkg::color_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED %s: expected %0d, actual %0d at %0t",
                 name, expected, actual, $time);
    end
endtask

task automatic report_failure(input string what);
    error_count++;
    $display("ERROR at %0t: %s", $time, what);
endtask

task automatic bus_write(input ppu_pkg::addr_t addr, input ppu_pkg::byte_t data);
    @(negedge clk);
    bus.addr  = addr;
    bus.wdata = data;
    bus.write = 1'b1;
    @(negedge clk);
    bus.write = 1'b0;
endtask

// Sampled one cycle after the address goes out
task automatic bus_read(input ppu_pkg::addr_t addr, output ppu_pkg::byte_t data);
    @(negedge clk);
    bus.addr  = addr;
    bus.write = 1'b0;
    @(negedge clk);
    data = mem_data_read;
endtask

function automatic ppu_pkg::color_t expected_shade(input ppu_pkg::byte_t x,
        input ppu_pkg::byte_t ly, input ppu_pkg::byte_t scx, input ppu_pkg::byte_t scy,
        input ppu_pkg::byte_t lcdc, input ppu_pkg::byte_t bgp);
    ppu_pkg::byte_t bx;
    ppu_pkg::byte_t by;
    ppu_pkg::byte_t lo;
    ppu_pkg::byte_t hi;
    int             map_off;
    int             tile_off;
    int             sidx;
    int             bit_pos;
    int             k;
    bx      = x + scx;
    by      = ly + scy;
    map_off = int'((lcdc[3] ? ppu_pkg::MAP_HIGH : ppu_pkg::MAP_LOW) - ppu_pkg::VRAM_BASE);
    map_off = map_off + 32 * int'(by[7:3]) + int'(bx[7:3]);
    if (lcdc[4]) begin
        tile_off = 16 * int'(vram_mem[map_off]);
    end else begin
        sidx     = $signed(vram_mem[map_off]);
        tile_off = int'(ppu_pkg::TILES_HIGH - ppu_pkg::VRAM_BASE) + 16 * sidx;
    end
    tile_off = tile_off + 2 * int'(by[2:0]);
    lo       = vram_mem[tile_off];
    hi       = vram_mem[tile_off + 1];
    bit_pos  = 7 - int'(bx[2:0]);  // Leftmost pixel in bit 7
    k        = 2 * int'(hi[bit_pos]) + int'(lo[bit_pos]);
    return bgp[2 * k +: 2];
endfunction

task automatic register_readback();
    ppu_pkg::addr_t addrs [5];
    ppu_pkg::byte_t values [5];
    ppu_pkg::byte_t value;
    int             tries;
    addrs  = '{ppu_pkg::REG_SCX, ppu_pkg::REG_SCY, ppu_pkg::REG_LYC, ppu_pkg::REG_BGP,
               ppu_pkg::REG_LCDC};
    values = '{8'h5A, 8'hC3, 8'h8D, 8'hE4, 8'h19};
    for (int i = 0; i < 5; i++)
        bus_write(addrs[i], values[i]);
    for (int i = 0; i < 5; i++) begin
        bus_read(addrs[i], value);
        check_byte($sformatf("readback %04h", addrs[i]), values[i], value);
    end
    bus_write(ppu_pkg::REG_LYC, 8'h00);
    // Enables in bits 6:3, LY == LYC, mode 0 while off
    bus_write(ppu_pkg::REG_STAT, 8'h78);
    bus_read(ppu_pkg::REG_STAT, value);
    check_byte("stat readback", 8'h7C, value);
    bus_write(ppu_pkg::REG_LCDC, 8'h99);
    bus_read(ppu_pkg::REG_STAT, value);
    check_byte("stat match at ly 0", 8'h04, value & 8'h04);
    bus_write(ppu_pkg::REG_LYC, 8'h01);
    bus_read(ppu_pkg::REG_STAT, value);
    check_byte("stat no match", 8'h00, value & 8'h04);
    tries = 0;
    do begin
        bus_read(ppu_pkg::REG_LY, value);
        tries++;
    end while (value != 8'h01 && tries < FRAME_CYCLES / 2);
    if (value != 8'h01)
        report_failure("LY never reached 1 after the display was enabled");
    bus_read(ppu_pkg::REG_STAT, value);
    check_byte("stat match at ly 1", 8'h04, value & 8'h04);
endtask

task automatic line_counter();
    ppu_pkg::byte_t value;
    bus_write(ppu_pkg::REG_LCDC, 8'h00);
    bus_write(ppu_pkg::REG_LCDC, 8'h91);
    repeat (200) @(negedge clk);  // Mid-line of line 0
    for (int i = 0; i < ppu_pkg::CYCLES_Y + 2; i++) begin
        bus_read(ppu_pkg::REG_LY, value);
        check_byte($sformatf("ly line %0d", i), ppu_pkg::byte_t'(i % ppu_pkg::CYCLES_Y), value);
        repeat (ppu_pkg::CYCLES_X - 2) @(negedge clk);
    end
    bus_write(ppu_pkg::REG_LY, 8'h37);
    bus_read(ppu_pkg::REG_LY, value);
    check_byte("ly after write", 8'h00, value);
endtask

task automatic vblank_period();
    int cycles;
    int pulses;
    int line;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!intreq_vblank && cycles <= FRAME_CYCLES);
    if (!intreq_vblank) begin
        report_failure("no vblank interrupt within one frame");
        return;
    end
    pulses = 0;
    for (int c = 1; c <= FRAME_CYCLES; c++) begin
        @(negedge clk);
        line = (ppu_pkg::PIX_Y + c / ppu_pkg::CYCLES_X) % ppu_pkg::CYCLES_Y;
        check_byte("lcd_vblank", {7'b0, line >= ppu_pkg::PIX_Y}, {7'b0, lcd_vblank});
        if (line >= ppu_pkg::PIX_Y && lcd_write)
            report_failure($sformatf("lcd_write during vblank on line %0d", line));
        if (intreq_vblank) begin
            pulses++;
            if (c != FRAME_CYCLES)
                report_failure($sformatf("vblank interrupt %0d cycles after the last", c));
        end
    end
    check_byte("vblank pulses per frame", 8'd1, ppu_pkg::byte_t'(pulses));
endtask

task automatic scan_line(input ppu_pkg::byte_t ly, input ppu_pkg::byte_t scx,
                         input ppu_pkg::byte_t scy, input ppu_pkg::byte_t lcdc,
                         input ppu_pkg::byte_t bgp);
    int    count;
    int    cycles;
    string name;
    count  = 0;
    cycles = 0;
    name   = $sformatf("scx %02h scy %02h lcdc %02h ly %0d", scx, scy, lcdc, ly);
    while (count < ppu_pkg::PIX_X && cycles < 2 * ppu_pkg::CYCLES_X) begin
        @(negedge clk);
        cycles++;
        if (lcd_write) begin
            check_byte({name, " x"}, ppu_pkg::byte_t'(count), lcd_x);
            check_byte({name, " y"}, ly, lcd_y);
            check_color({name, " col"},
                        expected_shade(ppu_pkg::byte_t'(count), ly, scx, scy, lcdc, bgp),
                        lcd_col);
            count++;
        end
    end
    if (count < ppu_pkg::PIX_X)
        report_failure($sformatf("%s: only %0d pixels written", name, count));
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (lcd_write)
            report_failure($sformatf("%s: pixel written after the 160th", name));
    end while (!lcd_hblank && cycles < 16);
    if (!lcd_hblank)
        report_failure($sformatf("%s: no hblank pulse after the line", name));
endtask

task automatic background_lines();
    ppu_pkg::byte_t scx_list [4];
    ppu_pkg::byte_t scy_list [4];
    ppu_pkg::byte_t lcdc_list [4];
    ppu_pkg::byte_t bgp;
    scx_list  = '{8'h00, 8'h03, 8'hFB, 8'h2E};
    scy_list  = '{8'h00, 8'h25, 8'hC9, 8'hFE};  // Last one wraps at the map bottom
    lcdc_list = '{8'h91, 8'h99, 8'h81, 8'h89};  // Both map selects, both tile modes
    for (int s = 0; s < 4; s++) begin
        bgp = ppu_pkg::byte_t'($urandom);
        bus_write(ppu_pkg::REG_LCDC, 8'h00);
        bus_write(ppu_pkg::REG_SCX, scx_list[s]);
        bus_write(ppu_pkg::REG_SCY, scy_list[s]);
        bus_write(ppu_pkg::REG_BGP, bgp);
        bus_write(ppu_pkg::REG_LCDC, lcdc_list[s]);
        for (int ly = 0; ly < LINES_PER_SETUP; ly++)
            scan_line(ppu_pkg::byte_t'(ly), scx_list[s], scy_list[s], lcdc_list[s], bgp);
    end
endtask

task automatic vram_access();
    ppu_pkg::addr_t addr;
    ppu_pkg::byte_t data;
    ppu_pkg::byte_t value;
    int             cycles;
    bus_write(ppu_pkg::REG_LCDC, 8'h00);
    for (int i = 0; i < 8; i++) begin
        addr = ppu_pkg::VRAM_BASE + ppu_pkg::addr_t'(i * 16'h03F1);
        data = ppu_pkg::byte_t'($urandom);
        bus_write(addr, data);
        check_byte($sformatf("vram model %04h", addr), data, vram_mem[addr[12:0]]);
        bus_read(addr, value);
        check_byte($sformatf("vram read %04h", addr), data, value);
    end
    bus_write(ppu_pkg::REG_LCDC, 8'h91);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!lcd_write && cycles < 2 * ppu_pkg::CYCLES_X);
    if (!lcd_write)
        report_failure("display enabled but no pixel was written");
    bus_read(ppu_pkg::VRAM_BASE, value);
    check_byte("vram read while drawing", 8'hFF, value);
endtask

`endif

// File: tb_ppu.sv
`timescale 1ns/1ns

module tb_ppu;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int FRAME_CYCLES    = ppu_pkg::CYCLES_X * ppu_pkg::CYCLES_Y;
    localparam int WATCHDOG_CYCLES = 5 * FRAME_CYCLES + 10000;
    localparam int LINES_PER_SETUP = 3;

    logic               clk;
    logic               reset;
    ppu_pkg::cpu_bus_t  bus;
    ppu_pkg::byte_t     mem_data_read;
    ppu_pkg::addr_t     vram_addr;
    ppu_pkg::byte_t     vram_data_w;
    ppu_pkg::byte_t     vram_data_r;
    logic               vram_do_write;
    logic               intreq_vblank;
    logic               lcd_write;
    logic               lcd_hblank;
    logic               lcd_vblank;
    ppu_pkg::color_t    lcd_col;
    ppu_pkg::byte_t     lcd_x;
    ppu_pkg::byte_t     lcd_y;

    ppu_pkg::byte_t     vram_mem [0:8191];
    int                 check_count;
    int                 error_count;

    ppu u_dut (
        .clk, .reset, .bus, .mem_data_read, .vram_addr, .vram_data_w, .vram_data_r,
        .vram_do_write, .intreq_vblank, .lcd_write, .lcd_hblank, .lcd_vblank,
        .lcd_col, .lcd_x, .lcd_y
    );

    // External VRAM returns data one cycle after the address
    always @(posedge clk) begin
        if (vram_do_write)
            vram_mem[vram_addr[12:0]] <= vram_data_w;
        vram_data_r <= vram_mem[vram_addr[12:0]];
    end

    `include "tb_ppu_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(24));
        check_count = 0;
        error_count = 0;
        reset       = 1'b1;
        bus         = '0;
        vram_data_r <= '0;
        // Random tile maps and tile data
        for (int i = 0; i < 8192; i++)
            vram_mem[i] <= ppu_pkg::byte_t'($urandom);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        register_readback();
        line_counter();
        vblank_period();
        background_lines();
        vram_access();

        @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: ppu.sv
`timescale 1ns/1ns

module ppu (
    input  logic              clk,
    input  logic              reset,
    input  ppu_pkg::cpu_bus_t bus,
    output ppu_pkg::byte_t    mem_data_read,
    output ppu_pkg::addr_t    vram_addr,
    output ppu_pkg::byte_t    vram_data_w,
    input  ppu_pkg::byte_t    vram_data_r,
    output logic              vram_do_write,
    output logic              intreq_vblank,
    output logic              lcd_write,
    output logic              lcd_hblank,
    output logic              lcd_vblank,
    output ppu_pkg::color_t   lcd_col,
    output ppu_pkg::byte_t    lcd_x,
    output ppu_pkg::byte_t    lcd_y
);

    ppu_pkg::ppu_ctrl_t ctrl;
    ppu_pkg::beam_t     beam;
    ppu_pkg::tile_row_t row;
    ppu_pkg::addr_t     fetch_addr;
    logic               fetch_active;
    logic               ly_reset;
    logic               drawing;
    logic               line_end;
    logic               row_valid;
    logic               row_ready;

    // Fetcher owns the VRAM port while active
    assign vram_addr     = fetch_active ? fetch_addr : bus.addr;
    assign vram_data_w   = bus.wdata;
    assign vram_do_write = !fetch_active && bus.write && ppu_pkg::is_vram(bus.addr);

    ppu_regs u_regs (
        .clk, .reset, .bus, .beam, .vram_data_r, .fetch_active,
        .mem_data_read, .ctrl, .ly_reset
    );

    ppu_timing u_timing (
        .clk, .reset, .ctrl, .ly_reset, .drawing, .beam, .intreq_vblank
    );

    bg_fetcher u_fetcher (
        .clk, .reset, .ctrl, .beam, .line_end, .vram_data_r,
        .fetch_active, .fetch_addr, .row, .row_valid, .row_ready
    );

    pixel_fifo u_fifo (
        .clk, .reset, .ctrl, .beam, .row, .row_valid, .row_ready,
        .drawing, .line_end, .lcd_write, .lcd_hblank, .lcd_vblank,
        .lcd_col, .lcd_x, .lcd_y
    );

endmodule

// File: pixel_fifo.sv
`timescale 1ns/1ns

module pixel_fifo (
    input  logic                clk,
    input  logic                reset,
    input  ppu_pkg::ppu_ctrl_t  ctrl,
    input  ppu_pkg::beam_t      beam,
    input  ppu_pkg::tile_row_t  row,
    input  logic                row_valid,
    output logic                row_ready,
    output logic                drawing,
    output logic                line_end,
    output logic                lcd_write,
    output logic                lcd_hblank,
    output logic                lcd_vblank,
    output ppu_pkg::color_t     lcd_col,
    output ppu_pkg::byte_t      lcd_x,
    output ppu_pkg::byte_t      lcd_y
);

    logic            active;
    ppu_pkg::byte_t  x_px;
    logic [4:0]      size;     // 0, 8 or 16 after a push
    logic [2:0]      discard;  // Fine scroll pixels still to drop
    logic [15:0]     shift_lo;
    logic [15:0]     shift_hi;
    logic            push;
    logic            pop;
    logic            line_done;
    ppu_pkg::color_t pix_idx;

    function automatic ppu_pkg::color_t palette(input ppu_pkg::byte_t pal,
                                                input ppu_pkg::color_t idx);
        return pal[2 * idx +: 2];
    endfunction

    assign drawing    = active;
    assign line_done  = active && x_px == ppu_pkg::PIX_X;
    assign row_ready  = active && size <= 5'd8;
    assign push       = row_valid && row_ready;
    assign pop        = active && size > 5'd8 && !line_done;
    assign pix_idx    = {shift_hi[15], shift_lo[15]};
    assign lcd_vblank = ctrl.display_enabled && beam.ly >= ppu_pkg::PIX_Y;

    always_ff @(posedge clk) begin
        lcd_write  <= 1'b0;
        lcd_hblank <= 1'b0;
        line_end   <= 1'b0;
        if (reset || !ctrl.display_enabled) begin
            active  <= 1'b0;
            x_px    <= '0;
            size    <= '0;
            discard <= '0;
        end else if (beam.line_start) begin
            active  <= 1'b1;
            x_px    <= '0;
            size    <= '0;
            discard <= ctrl.scx[2:0];
        end else if (line_done) begin
            active     <= 1'b0;
            size       <= '0;
            lcd_hblank <= 1'b1;
            line_end   <= 1'b1;
        end else if (push) begin
            size <= size + 5'd8;
        end else if (pop) begin
            size <= size - 1'b1;
            if (discard != 3'd0) begin
                discard <= discard - 1'b1;
            end else begin
                lcd_write <= 1'b1;
                x_px      <= x_px + 1'b1;
            end
        end
    end

    // Leftmost pixel sits in bit 15
    always_ff @(posedge clk) begin
        if (push) begin
            if (size == 5'd0) begin
                shift_lo <= {row.lo, 8'h00};
                shift_hi <= {row.hi, 8'h00};
            end else begin
                shift_lo[7:0] <= row.lo;
                shift_hi[7:0] <= row.hi;
            end
        end else if (pop) begin
            shift_lo <= {shift_lo[14:0], 1'b0};
            shift_hi <= {shift_hi[14:0], 1'b0};
        end
        if (pop) begin
            lcd_col <= palette(ctrl.bgp, pix_idx);
            lcd_x   <= x_px;
            lcd_y   <= beam.ly;
        end
    end

    size_max: assert property (@(posedge clk) disable iff (reset) size <= 5'd16);

endmodule

// File: bg_fetcher.sv
`timescale 1ns/1ns

module bg_fetcher (
    input  logic                clk,
    input  logic                reset,
    input  ppu_pkg::ppu_ctrl_t  ctrl,
    input  ppu_pkg::beam_t      beam,
    input  logic                line_end,
    input  ppu_pkg::byte_t      vram_data_r,
    output logic                fetch_active,
    output ppu_pkg::addr_t      fetch_addr,
    output ppu_pkg::tile_row_t  row,
    output logic                row_valid,
    input  logic                row_ready
);

    ppu_pkg::fetch_state_e state;
    logic [4:0]            tile_x;  // Column in the 32x32 map
    ppu_pkg::byte_t        tile_idx;
    ppu_pkg::byte_t        bg_y;
    ppu_pkg::addr_t        map_base;
    ppu_pkg::addr_t        map_addr;

    function automatic ppu_pkg::addr_t tile_addr(input ppu_pkg::byte_t idx,
                                                 input logic [2:0] fine_y,
                                                 input logic unsigned_idx,
                                                 input logic hi);
        logic           sign;
        ppu_pkg::addr_t base;
        sign = !unsigned_idx && idx[7];
        base = unsigned_idx ? ppu_pkg::TILES_LOW : ppu_pkg::TILES_HIGH;
        return base + {{4{sign}}, idx, fine_y, hi};  // 16 bytes per tile
    endfunction

    assign bg_y         = beam.ly + ctrl.scy;
    assign map_base     = ctrl.bg_map_select ? ppu_pkg::MAP_HIGH : ppu_pkg::MAP_LOW;
    assign map_addr     = map_base + {6'b0, bg_y[7:3], tile_x};
    assign fetch_active = state != ppu_pkg::STOPPED;

    always_ff @(posedge clk) begin
        if (reset || !ctrl.display_enabled || line_end) begin
            state     <= ppu_pkg::STOPPED;
            row_valid <= 1'b0;
        end else begin
            case (state)
                ppu_pkg::STOPPED:  if (beam.line_start) state <= ppu_pkg::START;
                ppu_pkg::START:    state <= ppu_pkg::WAIT_MAP;
                ppu_pkg::WAIT_MAP: state <= ppu_pkg::READ_MAP;
                ppu_pkg::READ_MAP: state <= ppu_pkg::WAIT_LO;
                ppu_pkg::WAIT_LO:  state <= ppu_pkg::READ_LO;
                ppu_pkg::READ_LO:  state <= ppu_pkg::WAIT_HI;
                ppu_pkg::WAIT_HI:  state <= ppu_pkg::READ_HI;
                ppu_pkg::READ_HI: begin
                    row_valid <= 1'b1;
                    state     <= ppu_pkg::WAIT_FIFO;
                end
                ppu_pkg::WAIT_FIFO: begin
                    if (row_ready) begin
                        row_valid <= 1'b0;
                        state     <= ppu_pkg::WAIT_MAP;
                    end
                end
                default: state <= ppu_pkg::STOPPED;
            endcase
        end
    end

    // Address goes out one cycle ahead of the READ state using its data
    always_ff @(posedge clk) begin
        case (state)
            ppu_pkg::STOPPED: tile_x <= ctrl.scx[7:3];
            ppu_pkg::START:   fetch_addr <= map_addr;
            ppu_pkg::READ_MAP: begin
                tile_idx   <= vram_data_r;
                fetch_addr <= tile_addr(vram_data_r, bg_y[2:0], ctrl.tile_data_select, 1'b0);
            end
            ppu_pkg::READ_LO: begin
                row.lo     <= vram_data_r;
                fetch_addr <= tile_addr(tile_idx, bg_y[2:0], ctrl.tile_data_select, 1'b1);
            end
            ppu_pkg::READ_HI: begin
                row.hi <= vram_data_r;
                tile_x <= tile_x + 1'b1;  // Wraps at map edge
            end
            ppu_pkg::WAIT_FIFO: fetch_addr <= map_addr;
            default: ;
        endcase
    end

    row_held: assert property (@(posedge clk) disable iff (reset)
        row_valid && !row_ready |=> $stable(row));

endmodule

// File: ppu_timing.sv
`timescale 1ns/1ns

module ppu_timing (
    input  logic               clk,
    input  logic               reset,
    input  ppu_pkg::ppu_ctrl_t ctrl,
    input  logic               ly_reset,
    input  logic               drawing,
    output ppu_pkg::beam_t     beam,
    output logic               intreq_vblank
);

    ppu_pkg::line_clk_t line_clk;
    ppu_pkg::line_clk_t line_clk_next;
    ppu_pkg::byte_t     ly;
    ppu_pkg::byte_t     ly_next;
    logic               line_last;

    assign line_last = line_clk == ppu_pkg::CYCLES_X - 1;

    always_comb begin
        line_clk_next = line_last ? '0 : line_clk + 1'b1;
        if (ly_reset)
            ly_next = '0;
        else if (!line_last)
            ly_next = ly;
        else if (ly == ppu_pkg::CYCLES_Y - 1)
            ly_next = '0;  // Frame wrap
        else
            ly_next = ly + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset || !ctrl.display_enabled) begin
            line_clk      <= '0;
            ly            <= '0;
            intreq_vblank <= 1'b0;
        end else begin
            line_clk      <= line_clk_next;
            ly            <= ly_next;
            intreq_vblank <= ly_next == ppu_pkg::PIX_Y && ly != ppu_pkg::PIX_Y;
        end
    end

    always_comb begin
        beam.ly = ly;
        if (!ctrl.display_enabled)
            beam.mode = ppu_pkg::MODE_HBLANK;
        else if (ly >= ppu_pkg::PIX_Y)
            beam.mode = ppu_pkg::MODE_VBLANK;
        else if (line_clk < ppu_pkg::OAM_CYCLES)
            beam.mode = ppu_pkg::MODE_OAM;
        else if (drawing)
            beam.mode = ppu_pkg::MODE_PIX;
        else
            beam.mode = ppu_pkg::MODE_HBLANK;
        beam.line_start = ctrl.display_enabled && line_clk == ppu_pkg::OAM_CYCLES
                          && ly < ppu_pkg::PIX_Y;
    end

    ly_in_frame: assert property (@(posedge clk) disable iff (reset)
        ly < ppu_pkg::CYCLES_Y && line_clk < ppu_pkg::CYCLES_X);

endmodule

// File: ppu_regs.sv
`timescale 1ns/1ns

module ppu_regs (
    input  logic                clk,
    input  logic                reset,
    input  ppu_pkg::cpu_bus_t   bus,
    input  ppu_pkg::beam_t      beam,
    input  ppu_pkg::byte_t      vram_data_r,
    input  logic                fetch_active,
    output ppu_pkg::byte_t      mem_data_read,
    output ppu_pkg::ppu_ctrl_t  ctrl,
    output logic                ly_reset
);

    ppu_pkg::byte_t lcdc;
    logic [3:0]     stat_en;  // LYC, OAM, VBLANK, HBLANK enables
    ppu_pkg::byte_t scy;
    ppu_pkg::byte_t scx;
    ppu_pkg::byte_t lyc;
    ppu_pkg::byte_t bgp;
    logic           ly_match;

    assign ly_match = beam.ly == lyc;

    // Any write to LY restarts the frame count
    assign ly_reset = bus.write && bus.addr == ppu_pkg::REG_LY;

    assign ctrl.display_enabled  = lcdc[7];
    assign ctrl.tile_data_select = lcdc[4];
    assign ctrl.bg_map_select    = lcdc[3];
    assign ctrl.scx              = scx;
    assign ctrl.scy              = scy;
    assign ctrl.bgp              = bgp;

    always_ff @(posedge clk) begin
        if (reset) begin
            lcdc    <= '0;
            stat_en <= '0;
            scy     <= '0;
            scx     <= '0;
            lyc     <= '0;
            bgp     <= '0;
        end else if (bus.write) begin
            case (bus.addr)
                ppu_pkg::REG_LCDC: lcdc <= bus.wdata;
                ppu_pkg::REG_STAT: stat_en <= bus.wdata[6:3];
                ppu_pkg::REG_SCY:  scy <= bus.wdata;
                ppu_pkg::REG_SCX:  scx <= bus.wdata;
                ppu_pkg::REG_LYC:  lyc <= bus.wdata;
                ppu_pkg::REG_BGP:  bgp <= bus.wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        if (ppu_pkg::is_vram(bus.addr)) begin
            // VRAM port belongs to the fetcher while it runs
            mem_data_read = fetch_active ? 8'hFF : vram_data_r;
        end else begin
            case (bus.addr)
                ppu_pkg::REG_LCDC: mem_data_read = lcdc;
                ppu_pkg::REG_STAT: mem_data_read = {1'b0, stat_en, ly_match, beam.mode};
                ppu_pkg::REG_SCY:  mem_data_read = scy;
                ppu_pkg::REG_SCX:  mem_data_read = scx;
                ppu_pkg::REG_LY:   mem_data_read = beam.ly;
                ppu_pkg::REG_LYC:  mem_data_read = lyc;
                ppu_pkg::REG_BGP:  mem_data_read = bgp;
                default:           mem_data_read = 8'hFF;
            endcase
        end
    end

endmodule

// File: ppu_pkg.sv
package ppu_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  line_clk_t;  // 0..455 within a line
    typedef logic [1:0]  color_t;

    // Beam timing
    localparam int OAM_CYCLES = 80;
    localparam int PIX_X      = 160;
    localparam int PIX_Y      = 144;
    localparam int CYCLES_X   = 456;   // OAM + pixel transfer + hblank
    localparam int CYCLES_Y   = 154;   // Visible lines + vblank

    localparam addr_t VRAM_BASE  = 16'h8000;
    localparam addr_t VRAM_SIZE  = 16'h2000;
    localparam addr_t MAP_LOW    = 16'h9800;
    localparam addr_t MAP_HIGH   = 16'h9C00;
    localparam addr_t TILES_LOW  = 16'h8000;
    localparam addr_t TILES_HIGH = 16'h9000;  // Signed tile index around this base

    localparam addr_t REG_LCDC = 16'hFF40;
    localparam addr_t REG_STAT = 16'hFF41;
    localparam addr_t REG_SCY  = 16'hFF42;
    localparam addr_t REG_SCX  = 16'hFF43;
    localparam addr_t REG_LY   = 16'hFF44;
    localparam addr_t REG_LYC  = 16'hFF45;
    localparam addr_t REG_DMA  = 16'hFF46;
    localparam addr_t REG_BGP  = 16'hFF47;
    localparam addr_t REG_OBP0 = 16'hFF48;
    localparam addr_t REG_OBP1 = 16'hFF49;

    typedef enum logic [1:0] {
        MODE_HBLANK = 2'd0,
        MODE_VBLANK = 2'd1,
        MODE_OAM    = 2'd2,
        MODE_PIX    = 2'd3
    } mode_t;

    typedef enum logic [3:0] {
        STOPPED, START, WAIT_MAP, READ_MAP, WAIT_LO, READ_LO, WAIT_HI, READ_HI, WAIT_FIFO
    } fetch_state_e;

    typedef struct packed {
        addr_t addr;
        byte_t wdata;
        logic  write;
    } cpu_bus_t;

    typedef struct packed {
        logic  display_enabled;
        logic  bg_map_select;
        logic  tile_data_select;
        byte_t scx;
        byte_t scy;
        byte_t bgp;
    } ppu_ctrl_t;

    typedef struct packed {
        byte_t ly;
        mode_t mode;
        logic  line_start;
    } beam_t;

    typedef struct packed {
        byte_t lo;
        byte_t hi;
    } tile_row_t;

    function automatic logic is_vram(addr_t addr);
        return addr >= VRAM_BASE && addr < VRAM_BASE + VRAM_SIZE;
    endfunction

endpackage
